// File: axi_cmd_master.f
+incdir+source
source/axi_pkg.sv
source/cmd_pkg.sv
source/cmd_window_decode.sv
source/addr_channel_issue.sv
source/burst_addr_gen.sv
source/data_beat_path.sv
source/axi_cmd_master.sv
sim/axi_cmd_master_tb.sv

// File: sim/axi_cmd_master_tb.sv
/*
 * Testbench for the command driven AXI4 master.
 * Behavioral slave with random stalls, directed and random bursts,
 * and beat by beat checks against a reference address model.
 */
`timescale 1ns/10ps
`include "master_params.svh"

module axi_cmd_master_tb import axi_pkg::*, cmd_pkg::*; ();

    localparam logic [31:0] SEED = 32'h93e4_0969;
    localparam int RAND_PAIRS = 6;
    // directed bursts plus both directions of each random pair
    localparam int NUM_BURSTS = 8 + 2 * RAND_PAIRS;
    localparam int CYCLE_LIMIT = 40 * NUM_BURSTS + 100;

    logic clk = 1'b0;
    logic rst_n = 1'b0;

    // user side
    cmd_t aw_cmd, ar_cmd;
    logic aw_cmd_valid, ar_cmd_valid;
    logic [`DATA_W-1:0] write_data = '0;
    logic write_valid = 1'b0;
    logic aw_flag, ar_flag, read_valid;
    logic [`ADDR_W-`ADDR_LSB-1:0] w_opt_addr, r_opt_addr;
    logic [`DATA_W-1:0] read_data;

    // AXI side
    addr_chan_t aw, ar;
    logic awvalid, arvalid, wvalid, wlast, bready, rready;
    logic [`DATA_W-1:0] wdata;
    logic [`DATA_W/8-1:0] wstrb;
    logic awready = 1'b0, arready = 1'b0, wready = 1'b0;
    logic bvalid = 1'b0, rvalid = 1'b0, rlast = 1'b0;
    logic [`DATA_W-1:0] rdata = '0;
    resp_e bresp = OKAY, rresp = OKAY;

    // slave and checker state
    logic [31:0] bus_rng = SEED;
    logic [31:0] stim_rng;
    logic [`DATA_W-1:0] rdata_q[$];
    int r_todo = 0, wr_idx = 0, cycle_cnt = 0;
    cmd_t w_exp, r_exp, w_cur, r_cur;
    int w_sent = 0, r_sent = 0, aw_cnt = 0, ar_cnt = 0, b_cnt = 0, rd_cnt = 0;
    int w_idx = 0, r_idx = 0, w_seen = 0;
    logic aw_rise = 1'b0, aw_fall = 1'b0, ar_rise = 1'b0, ar_fall = 1'b0;

    axi_cmd_master axi_cmd_master_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`DATA_W-1:0] word_pattern(input int n);
        return 32'ha5a5_0000 + n * 32'h0001_0003;
    endfunction

    function automatic cmd_t mk_cmd(input logic [`ADDR_W-1:0] addr,
                                    input logic [`LEN_W-1:0] len, input burst_e burst);
        cmd_t c;
        c.addr = addr;
        c.len = len;
        c.burst = burst;
        return c;
    endfunction

    function automatic addr_chan_t expect_chan(input cmd_t c);
        addr_chan_t e;
        e.addr = c.addr;
        e.len = c.len;
        e.size = `AXI_SIZE_CODE;
        e.burst = c.burst;
        return e;
    endfunction

    // address of a given beat, stepped one beat at a time from the start
    function automatic addr_view_u ref_beat_addr(input logic [`ADDR_W-1:0] start,
            input logic [`LEN_W-1:0] len, input burst_e burst, input int beat);
        addr_view_u a;
        logic [`ADDR_W-`ADDR_LSB-1:0] blk;
        logic [`ADDR_W-`ADDR_LSB-1:0] base;
        int i;
        a.flat = start;
        blk = '0;
        if (len == 1 || len == 3 || len == 7 || len == 15) begin
            blk = len;
        end
        // wrap block starts at the start word with its low bits cleared
        base = a.split.word & ~blk;
        for (i = 0; i < beat; i++) begin
            if (burst == WRAP) begin
                if (a.split.word == base + blk) begin
                    a.split.word = base;
                end else begin
                    a.split.word = a.split.word + 1'b1;
                end
                a.split.offset = '0;
            end else if (burst != FIXED) begin
                a.split.word = a.split.word + 1'b1;
                a.split.offset = '0;
            end
        end
        return a;
    endfunction

    // user port shows the word index only
    function automatic addr_view_u word_view(input logic [`ADDR_W-`ADDR_LSB-1:0] w);
        addr_view_u v;
        v.split.word = w;
        v.split.offset = '0;
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_chan(input string name, input addr_chan_t got, input addr_chan_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_view_u got, input addr_view_u exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_resp_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    // one strobe cycle per direction, counted only if it should be accepted
    task automatic issue_cmds(input cmd_t wc, input bit w_go, input bit w_ok,
                              input cmd_t rc, input bit r_go, input bit r_ok);
        @(posedge clk);
        aw_cmd <= wc;
        ar_cmd <= rc;
        aw_cmd_valid <= w_go;
        ar_cmd_valid <= r_go;
        if (w_go && w_ok) begin
            w_exp <= wc;
            w_sent <= w_sent + 1;
        end
        if (r_go && r_ok) begin
            r_exp <= rc;
            r_sent <= r_sent + 1;
        end
        @(posedge clk);
        aw_cmd_valid <= 1'b0;
        ar_cmd_valid <= 1'b0;
    endtask

    // wait for all accepted bursts, then no stray address phase may follow
    task automatic wait_done();
        while (b_cnt != w_sent || rd_cnt != r_sent) begin
            @(posedge clk);
        end
        repeat (4) begin
            @(posedge clk);
            check_resp_flag("awvalid", awvalid, 1'b0);
            check_resp_flag("arvalid", arvalid, 1'b0);
        end
    endtask

    // slave model and write data source
    always @(posedge clk) begin
        bus_rng = lcg_step(bus_rng);
        if (!rst_n) begin
            awready <= 1'b0;
            arready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            write_valid <= 1'b0;
            write_data <= word_pattern(0);
            wr_idx <= 0;
            r_todo <= 0;
        end else begin
            awready <= |bus_rng[17:16];
            arready <= |bus_rng[19:18];
            wready <= |bus_rng[21:20];
            write_valid <= |bus_rng[24:22];
            if (wvalid && wready) begin
                wr_idx <= wr_idx + 1;
                write_data <= word_pattern(wr_idx + 1);
            end
            if (wvalid && wready && wlast) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                r_todo <= ar.len + 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            // next R beat only once the current one is taken
            if ((!rvalid || rready) && r_todo != 0 && |bus_rng[27:26]) begin
                rvalid <= 1'b1;
                rdata <= bus_rng;
                rlast <= (r_todo == 1);
                r_todo <= r_todo - 1;
                rdata_q.push_back(bus_rng);
            end
        end
    end

    always @(posedge clk) begin : compare
        addr_view_u exp_a;
        logic w_busy;
        logic w_open;
        logic r_busy;
        if (rst_n) begin
            // burst state from the handshakes counted so far
            w_busy = (aw_cnt != b_cnt);
            w_open = w_busy && (w_idx <= w_cur.len);
            r_busy = (ar_cnt != rd_cnt);
            aw_rise <= 1'b0;
            aw_fall <= 1'b0;
            ar_rise <= 1'b0;
            ar_fall <= 1'b0;
            if (aw_rise || aw_fall) begin
                check_resp_flag("aw_flag", aw_flag, aw_rise);
            end
            if (ar_rise || ar_fall) begin
                check_resp_flag("ar_flag", ar_flag, ar_rise);
            end
            check_resp_flag("wvalid", wvalid, write_valid && w_open);
            check_resp_flag("bready", bready, w_busy && !w_open);
            check_resp_flag("rready", rready, r_busy);
            check_resp_flag("read_valid", read_valid, rvalid && r_busy);
            if (awvalid && awready) begin
                if (aw_cnt >= w_sent) begin
                    abort_run("write address phase seen with no write command outstanding");
                end
                check_chan("aw", aw, expect_chan(w_exp));
                aw_cnt <= aw_cnt + 1;
                w_cur <= w_exp;
                w_idx <= 0;
                aw_rise <= 1'b1;
            end
            if (arvalid && arready) begin
                if (ar_cnt >= r_sent) begin
                    abort_run("read address phase seen with no read command outstanding");
                end
                check_chan("ar", ar, expect_chan(r_exp));
                ar_cnt <= ar_cnt + 1;
                r_cur <= r_exp;
                r_idx <= 0;
                ar_rise <= 1'b1;
            end
            if (wvalid && wready) begin
                exp_a = ref_beat_addr(w_cur.addr, w_cur.len, w_cur.burst, w_idx);
                check_addr("w_opt_addr", word_view(w_opt_addr), word_view(exp_a.split.word));
                check_data("wdata", wdata, word_pattern(w_seen));
                check_data("wstrb", wstrb, {(`DATA_W/8){1'b1}});
                check_resp_flag("wlast", wlast, w_idx == w_cur.len);
                w_idx <= w_idx + 1;
                w_seen <= w_seen + 1;
            end
            if (bvalid && bready) begin
                check_data("write beat count", w_idx, w_cur.len + 1);
                b_cnt <= b_cnt + 1;
                aw_fall <= 1'b1;
            end
            if (rvalid && rready) begin
                exp_a = ref_beat_addr(r_cur.addr, r_cur.len, r_cur.burst, r_idx);
                check_addr("r_opt_addr", word_view(r_opt_addr), word_view(exp_a.split.word));
                if (rdata_q.size() == 0) begin
                    abort_run("read beat arrived with no data recorded by the slave");
                end
                check_data("read_data", read_data, rdata_q.pop_front());
                if (rlast) begin
                    check_data("read beat count", r_idx, r_cur.len);
                    rd_cnt <= rd_cnt + 1;
                    ar_fall <= 1'b1;
                end
                r_idx <= r_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        cmd_t wc;
        cmd_t rc;
        int i;
        aw_cmd = '0;
        ar_cmd = '0;
        aw_cmd_valid = 1'b0;
        ar_cmd_valid = 1'b0;
        stim_rng = lcg_step(SEED);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_data("control outputs after reset",
                   {awvalid, arvalid, wvalid, wlast, bready, rready, aw_flag, ar_flag,
                    read_valid}, '0);

        issue_cmds(mk_cmd(32'h100, 7, INCR), 1, 1, '0, 0, 0);
        wait_done();
        // wrap read from the middle of its block
        issue_cmds('0, 0, 0, mk_cmd(32'h208, 3, WRAP), 1, 1);
        wait_done();
        issue_cmds(mk_cmd(32'h040, 3, FIXED), 1, 1, mk_cmd(32'h044, 2, FIXED), 1, 1);
        wait_done();
        issue_cmds(mk_cmd(32'h080, 2, RSVD), 1, 1, mk_cmd(32'h300, 4, RSVD), 1, 1);
        wait_done();
        // outside the window in both directions
        issue_cmds(mk_cmd(32'h400, 3, INCR), 1, 0, mk_cmd(32'h7f0, 1, INCR), 1, 0);
        wait_done();
        // second command while the channel is busy
        issue_cmds(mk_cmd(32'h020, 5, INCR), 1, 1, '0, 0, 0);
        while (!aw_flag) @(posedge clk);
        issue_cmds(mk_cmd(32'h200, 1, INCR), 1, 0, '0, 0, 0);
        wait_done();
        issue_cmds('0, 0, 0, mk_cmd(32'h0c0, 5, INCR), 1, 1);
        while (!ar_flag) @(posedge clk);
        issue_cmds('0, 0, 0, mk_cmd(32'h210, 1, INCR), 1, 0);
        wait_done();

        // concurrent random bursts
        for (i = 0; i < RAND_PAIRS; i++) begin
            stim_rng = lcg_step(stim_rng);
            wc = mk_cmd(stim_rng & 32'h3ff, stim_rng[13:10], burst_e'(stim_rng[15:14]));
            stim_rng = lcg_step(stim_rng);
            rc = mk_cmd(stim_rng & 32'h3ff, stim_rng[13:10], burst_e'(stim_rng[15:14]));
            issue_cmds(wc, 1, 1, rc, 1, 1);
            wait_done();
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: source/axi_cmd_master.sv
/*
 * Command driven AXI4 master.
 * Two independent address channels for write and read, each with
 * decode, issue and burst address stages, around one data beat path.
 */
`timescale 1ns/10ps
`include "master_params.svh"

module axi_cmd_master import axi_pkg::*, cmd_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    // user command side
    input  cmd_t                          aw_cmd,
    input  logic                          aw_cmd_valid,
    input  cmd_t                          ar_cmd,
    input  logic                          ar_cmd_valid,
    output logic                          aw_flag,
    output logic                          ar_flag,
    output logic [`ADDR_W-`ADDR_LSB-1:0]  w_opt_addr,
    output logic [`ADDR_W-`ADDR_LSB-1:0]  r_opt_addr,
    input  logic [`DATA_W-1:0]            write_data,
    input  logic                          write_valid,
    output logic [`DATA_W-1:0]            read_data,
    output logic                          read_valid,
    // AXI address channels
    output addr_chan_t                    aw,
    output logic                          awvalid,
    input  logic                          awready,
    output addr_chan_t                    ar,
    output logic                          arvalid,
    input  logic                          arready,
    // AXI data and response channels
    output logic [`DATA_W-1:0]            wdata,
    output logic [`DATA_W/8-1:0]          wstrb,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  resp_e                         bresp,
    input  logic                          bvalid,
    output logic                          bready,
    input  logic [`DATA_W-1:0]            rdata,
    input  resp_e                         rresp,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready
);

    logic       aw_pend;
    logic       ar_pend;
    cmd_t       aw_pend_cmd;
    cmd_t       ar_pend_cmd;
    logic       aw_load;
    logic       ar_load;
    addr_view_u w_cur;
    addr_view_u r_cur;
    logic       w_last_beat;
    logic       r_last_beat;
    logic       w_beat;
    logic       r_beat;
    logic       w_done;
    logic       r_done;

    // write channel
    cmd_window_decode aw_decode_i (
        .clk(clk), .rst_n(rst_n), .cmd_valid(aw_cmd_valid), .cmd(aw_cmd),
        .busy(aw_flag), .load(aw_load), .pend(aw_pend), .pend_cmd(aw_pend_cmd)
    );

    addr_channel_issue aw_issue_i (
        .clk(clk), .rst_n(rst_n), .pend(aw_pend), .pend_cmd(aw_pend_cmd),
        .done(w_done), .load(aw_load), .chan(aw), .chan_valid(awvalid),
        .chan_ready(awready), .busy(aw_flag)
    );

    burst_addr_gen w_addr_i (
        .clk(clk), .rst_n(rst_n), .load(aw_load), .pend_cmd(aw_pend_cmd),
        .beat(w_beat), .cur_addr(w_cur), .last_beat(w_last_beat)
    );

    // read channel
    cmd_window_decode ar_decode_i (
        .clk(clk), .rst_n(rst_n), .cmd_valid(ar_cmd_valid), .cmd(ar_cmd),
        .busy(ar_flag), .load(ar_load), .pend(ar_pend), .pend_cmd(ar_pend_cmd)
    );

    addr_channel_issue ar_issue_i (
        .clk(clk), .rst_n(rst_n), .pend(ar_pend), .pend_cmd(ar_pend_cmd),
        .done(r_done), .load(ar_load), .chan(ar), .chan_valid(arvalid),
        .chan_ready(arready), .busy(ar_flag)
    );

    burst_addr_gen r_addr_i (
        .clk(clk), .rst_n(rst_n), .load(ar_load), .pend_cmd(ar_pend_cmd),
        .beat(r_beat), .cur_addr(r_cur), .last_beat(r_last_beat)
    );

    data_beat_path data_i (
        .clk(clk), .rst_n(rst_n), .aw_flag(aw_flag), .ar_flag(ar_flag),
        .w_last_beat(w_last_beat), .write_data(write_data), .write_valid(write_valid),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .read_data(read_data), .read_valid(read_valid),
        .w_beat(w_beat), .r_beat(r_beat), .w_done(w_done), .r_done(r_done)
    );

    assign w_opt_addr = w_cur.split.word;
    assign r_opt_addr = r_cur.split.word;

    // slave rlast agrees with the local beat count
    a_rlast_count: assert property (@(posedge clk) disable iff (!rst_n)
        r_done |-> r_last_beat);

    a_rresp_ok: assert property (@(posedge clk) disable iff (!rst_n)
        r_beat |-> rresp inside {OKAY, EXOKAY});

endmodule

// File: source/data_beat_path.sv
/*
 * Data beat path.
 * Gates user data onto W, marks the final beat and waits on B.
 * Holds rready for a read burst and forwards R beats to the user.
 */
`timescale 1ns/10ps
`include "master_params.svh"

module data_beat_path import axi_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  aw_flag,
    input  logic                  ar_flag,
    input  logic                  w_last_beat,
    input  logic [`DATA_W-1:0]    write_data,
    input  logic                  write_valid,
    output logic [`DATA_W-1:0]    wdata,
    output logic [`DATA_W/8-1:0]  wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  resp_e                 bresp,
    input  logic                  bvalid,
    output logic                  bready,
    input  logic [`DATA_W-1:0]    rdata,
    input  logic                  rlast,
    input  logic                  rvalid,
    output logic                  rready,
    output logic [`DATA_W-1:0]    read_data,
    output logic                  read_valid,
    output logic                  w_beat,
    output logic                  r_beat,
    output logic                  w_done,
    output logic                  r_done
);

    // all W beats taken, waiting on B
    logic w_sent;
    logic w_open;

    assign w_open = aw_flag && !w_sent;

    // write data, full words only
    assign wdata  = write_data;
    assign wstrb  = '1;
    assign wvalid = w_open && write_valid;
    assign wlast  = w_open && w_last_beat;
    assign w_beat = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_sent <= 1'b0;
        end else if (bvalid && bready) begin
            w_sent <= 1'b0;
        end else if (w_beat && w_last_beat) begin
            w_sent <= 1'b1;
        end
    end

    assign bready = w_sent;
    assign w_done = bvalid && bready;

    // read side, accept beats for the whole burst
    assign rready     = ar_flag;
    assign r_beat     = rvalid && rready;
    assign read_valid = r_beat;
    assign read_data  = rdata;
    assign r_done     = r_beat && rlast;

    // the address generator steps past len on the final beat
    a_wlast_final: assert property (@(posedge clk) disable iff (!rst_n)
        w_beat && wlast |=> !w_last_beat);

    // in-window writes should not be refused by the slave
    a_bresp_ok: assert property (@(posedge clk) disable iff (!rst_n)
        w_done |-> bresp inside {OKAY, EXOKAY});

endmodule

// File: source/burst_addr_gen.sv
/*
 * Burst address generator.
 * Steps the word address beat by beat as FIXED, INCR or WRAP
 * and flags the final beat of the burst.
 */
`timescale 1ns/10ps
`include "master_params.svh"

module burst_addr_gen import axi_pkg::*, cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  cmd_t       pend_cmd,
    input  logic       beat,
    output addr_view_u cur_addr,
    output logic       last_beat
);

    logic [`LEN_W-1:0]            len_q;
    logic [`LEN_W-1:0]            cnt;
    logic [`LEN_W-1:0]            wrap_mask;
    burst_e                       burst_q;
    logic [`ADDR_W-`ADDR_LSB-1:0] mask_w;
    logic [`ADDR_W-`ADDR_LSB-1:0] wrap_base;
    addr_view_u                   addr_nxt;

    // low word bits that wrap, only for the legal wrap lengths
    function automatic logic [`LEN_W-1:0] wrap_mask_of(input logic [`LEN_W-1:0] len);
        case (len)
            1, 3, 7, 15: wrap_mask_of = len;
            default:     wrap_mask_of = '0;
        endcase
    endfunction

    assign mask_w    = {{(`ADDR_W-`ADDR_LSB-`LEN_W){1'b0}}, wrap_mask};
    assign wrap_base = cur_addr.split.word & ~mask_w;

    always_comb begin
        addr_nxt = cur_addr;
        case (burst_q)
            FIXED: addr_nxt = cur_addr;
            WRAP: begin
                addr_nxt.split.word   = wrap_base | ((cur_addr.split.word + 1'b1) & mask_w);
                addr_nxt.split.offset = '0;
            end
            // INCR, reserved code runs as INCR
            default: begin
                addr_nxt.split.word   = cur_addr.split.word + 1'b1;
                addr_nxt.split.offset = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= '0;
            len_q   <= '0;
            burst_q <= INCR;
        end else if (load) begin
            cnt     <= '0;
            len_q   <= pend_cmd.len;
            burst_q <= pend_cmd.burst;
        end else if (beat) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cur_addr.flat <= pend_cmd.addr;
            wrap_mask     <= wrap_mask_of(pend_cmd.len);
        end else if (beat) begin
            cur_addr <= addr_nxt;
        end
    end

    assign last_beat = (cnt == len_q);

endmodule

// File: source/addr_channel_issue.sv
/*
 * Address channel issue.
 * Turns a pending command into an AW or AR address phase, holds it
 * under back-pressure and owns the channel busy flag until done.
 */
`timescale 1ns/10ps
`include "master_params.svh"

module addr_channel_issue import axi_pkg::*, cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pend,
    input  cmd_t       pend_cmd,
    input  logic       done,
    output logic       load,
    output addr_chan_t chan,
    output logic       chan_valid,
    input  logic       chan_ready,
    output logic       busy
);

    logic start;

    // new address phase only when nothing is outstanding
    assign start = pend && !chan_valid && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan_valid <= 1'b0;
            load       <= 1'b0;
            busy       <= 1'b0;
        end else begin
            load <= 1'b0;
            if (start) begin
                chan_valid <= 1'b1;
                load       <= 1'b1;
            end else if (chan_valid && chan_ready) begin
                chan_valid <= 1'b0;
                busy       <= 1'b1;
            end
            // end of data phase from the beat path
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            chan.addr  <= pend_cmd.addr;
            chan.len   <= pend_cmd.len;
            chan.size  <= `AXI_SIZE_CODE;
            chan.burst <= pend_cmd.burst;
        end
    end

    // payload must not move while the slave stalls
    a_chan_stable: assert property (@(posedge clk) disable iff (!rst_n)
        chan_valid && !chan_ready |=> chan_valid && $stable(chan));

    // completion only for a burst that was actually issued
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> busy);

endmodule

// File: source/cmd_window_decode.sv
/*
 * Command window decode.
 * Captures a user command whose address lies inside the master
 * window while the channel is idle and holds it for issue.
 */
`timescale 1ns/10ps
`include "master_params.svh"

module cmd_window_decode import cmd_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic cmd_valid,
    input  cmd_t cmd,
    input  logic busy,
    input  logic load,
    output logic pend,
    output cmd_t pend_cmd
);

    logic issued;
    logic in_window;
    logic accept;

    assign in_window = (cmd.addr >= `WIN_ST) && (cmd.addr < `WIN_END);

    // one burst per channel, so anything already in flight blocks
    assign accept = cmd_valid && in_window && !busy && !pend && !issued;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend   <= 1'b0;
            issued <= 1'b0;
        end else begin
            if (accept) begin
                pend <= 1'b1;
            end else if (load) begin
                pend <= 1'b0;
            end
            // covers the address phase until busy takes over
            if (load) begin
                issued <= 1'b1;
            end else if (busy) begin
                issued <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_cmd <= cmd;
        end
    end

    // a held command never overlaps a running burst
    a_pend_idle: assert property (@(posedge clk) disable iff (!rst_n)
        pend |-> !busy);

endmodule

// File: source/cmd_pkg.sv
/*
 * User command side types.
 * The command word and a view of an address as flat
 * or as word index plus byte offset.
 */
`include "master_params.svh"

package cmd_pkg;

    // command as the user presents it
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]  len;
        axi_pkg::burst_e    burst;
    } cmd_t;

    // word index and byte offset of one address
    typedef struct packed {
        logic [`ADDR_W-`ADDR_LSB-1:0] word;
        logic [`ADDR_LSB-1:0]         offset;
    } addr_split_t;

    typedef union packed {
        logic [`ADDR_W-1:0] flat;
        addr_split_t        split;
    } addr_view_u;

endpackage

// File: source/axi_pkg.sv
/*
 * AXI bus side types.
 * Burst and response codes and the AW/AR address payload
 * shared by the write and read channels.
 */
`include "master_params.svh"

package axi_pkg;

    // burst type field of AW/AR
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10,
        RSVD  = 2'b11
    } burst_e;

    // B and R response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // address phase payload, same layout for AW and AR
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]  len;
        logic [2:0]         size;
        burst_e             burst;
    } addr_chan_t;

endpackage

// File: source/master_params.svh
/*
 * Master parameters.
 * Bus widths, the accepted address window and the AXI size code.
 */
`ifndef MASTER_PARAMS_SVH
`define MASTER_PARAMS_SVH

`define ADDR_W 32
`define DATA_W 32
`define LEN_W 8

// byte offset bits of a data word
`define ADDR_LSB 2

// accepted window, end excluded
`define WIN_ST 32'h0000_0000
`define WIN_END 32'h0000_0400

`define AXI_SIZE_CODE 3'd2

`endif
